/* project.f */
+incdir+.
adc_stream_pkg.sv
adc_ctrl_pkg.sv
adc_stream_mux.sv
async_sample_fifo.sv
adc_apb_regs.sv
adc_retime_top.sv
tb_adc_retime.sv

/* tb_adc_retime.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module tb_adc_retime;

  import adc_stream_pkg::*;
  import adc_ctrl_pkg::*;

  localparam int FIFO_DEPTH   = 1 << `ADC_FIFO_DEPTH_LOG2;
  localparam int ORDER_BEATS  = 24;
  localparam int LAT_BEATS    = 12;
  localparam int OVF_BEATS    = 7;
  localparam int OFF_BEATS    = 4;
  // 40 wr_clk cycles per beat plus fixed slack
  localparam int TIMEOUT_CYCLES =
    40 * (ORDER_BEATS + LAT_BEATS + OVF_BEATS + OFF_BEATS) + 2000;

  logic        wr_clk;
  logic        rd_clk;
  logic        rst_n;
  adc_beat_t   din;
  logic        dvld;
  logic        rd_en;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  adc_sample_t dout;
  logic        dout_vld;
  logic        fifo_empty;
  logic        fifo_of;
  logic        fifo_uf;

  int          seed;
  int          rd_seed;
  // expected samples with the next dout at the head
  adc_sample_t model_q[$];
  logic        model_en     = 1'b0;
  logic        watch_empty  = 1'b0;
  logic        stop_rd      = 1'b0;
  logic [2:0]  take_pipe    = 3'b000;
  int          error_count  = 0;
  int          check_count  = 0;
  int          tests_failed = 0;
  int          exp_drops    = 0;
  int          cycle_count  = 0;
  int          of_pulses    = 0;
  int          uf_pulses    = 0;
  int          vld_count    = 0;

  adc_retime_top uut (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .din        (din),
    .dvld       (dvld),
    .rd_en      (rd_en),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .dout       (dout),
    .dout_vld   (dout_vld),
    .fifo_empty (fifo_empty),
    .fifo_of    (fifo_of),
    .fifo_uf    (fifo_uf)
  );

  initial begin
    wr_clk = 1'b0;
    forever #2 wr_clk = ~wr_clk;
  end

  // read domain clock with its own period
  initial begin
    rd_clk = 1'b0;
    forever #3 rd_clk = ~rd_clk;
  end

  task automatic check_sample(input adc_sample_t got, input adc_sample_t exp, input string name);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic int pick_gap(input int base, input int span);
    return base + ({$random(seed)} % span);
  endfunction

  // one beat with dvld high for a single wr_clk cycle
  task automatic send_beat(input int gap);
    adc_beat_t   beat;
    adc_sample_t s;
    logic [31:0] r;
    for (int i = 0; i < `ADC_SAMPLES_PER_BEAT; i++) begin
      r = $random(seed);
      beat[i] = r[`ADC_SAMPLE_W-1:0];
    end
    @(posedge wr_clk);
    din  <= beat;
    dvld <= 1'b1;
    if (model_en) begin
      for (int i = 0; i < `ADC_SAMPLES_PER_BEAT; i++) begin
        s.sync = (i == 0);
        s.data = beat[i];
        // fifo drops whole samples once 16 are held
        if (model_q.size() < FIFO_DEPTH) begin
          model_q.push_back(s);
        end else begin
          exp_drops++;
        end
      end
    end
    @(posedge wr_clk);
    dvld <= 1'b0;
    repeat (gap - 1) @(posedge wr_clk);
  endtask

  task automatic set_rd_en(input logic v);
    @(posedge rd_clk);
    rd_en <= v;
  endtask

  // setup phase followed by one access phase with no wait states
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    @(posedge rd_clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge rd_clk);
    apb_req.penable <= 1'b1;
    @(negedge rd_clk);
    check_flag(apb_rsp.pready, 1'b1, "pready");
    rdata = apb_rsp.prdata;
    @(posedge rd_clk);
    apb_req <= '0;
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rdata;
    apb_xfer(1'b0, addr, 32'h0, rdata);
    check_word(rdata, exp, name);
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) @(negedge rd_clk);
    repeat (8) @(negedge rd_clk);
  endtask

  task automatic report_test(input int num, input string title, input int errs_before);
    if (error_count == errs_before) begin
      $display("test %0d %s: ok", num, title);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, title, error_count - errs_before);
    end
  endtask

  // read side monitor on the falling rd_clk edge
  always @(negedge rd_clk) begin
    adc_sample_t exp;
    if (rst_n) begin
      // dout_vld follows a taken read by two rd_clk edges
      check_flag(dout_vld, take_pipe[2], "dout_vld");
      take_pipe = {take_pipe[1:0], rd_en && !fifo_empty};
      if (dout_vld) begin
        vld_count++;
        if (model_q.size() == 0) begin
          error_count++;
          $display("dout_vld was high with no sample expected from the model");
        end else begin
          exp = model_q.pop_front();
          check_sample(dout, exp, "dout");
        end
      end
      if (fifo_of) begin
        of_pulses++;
      end
      if (fifo_uf) begin
        uf_pulses++;
      end
      if (watch_empty && !fifo_empty) begin
        error_count++;
        $display("fifo_empty went low while capture was disabled");
      end
    end
  end

  always @(posedge wr_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d wr_clk cycles, test sequence did not finish", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin : main
    int          errs;
    int          n;
    int          i;
    int          of_before;
    int          uf_before;
    int          vld_before;
    logic [31:0] rdata;
    logic [31:0] r;

    din     = '0;
    dvld    = 1'b0;
    rd_en   = 1'b0;
    apb_req = '0;
    rst_n   = 1'b0;
    seed    = 32'hb9d46d38;
    rd_seed = $random(seed);
    repeat (2) @(posedge wr_clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge rd_clk);

    // ordering and sync with reads always on
    errs = error_count;
    apb_xfer(1'b1, `ADC_REG_CTRL, 32'h1, rdata);
    read_check(`ADC_REG_CTRL, 32'h1, "CTRL");
    repeat (5) @(posedge wr_clk);
    set_rd_en(1'b1);
    vld_before = vld_count;
    model_en   = 1'b1;
    for (i = 0; i < ORDER_BEATS; i++) begin
      send_beat(pick_gap(8, 8));
    end
    wait_drain();
    check_word(vld_count - vld_before, 4 * ORDER_BEATS, "dout_vld count");
    report_test(1, "ordering and sync", errs);

    // random rd_en exercises the read latency
    errs    = error_count;
    stop_rd = 1'b0;
    fork
      begin
        for (i = 0; i < LAT_BEATS; i++) begin
          send_beat(pick_gap(16, 8));
        end
        wait_drain();
        stop_rd = 1'b1;
      end
      begin
        while (!stop_rd) begin
          @(posedge rd_clk);
          r = $random(rd_seed);
          rd_en <= r[0];
        end
      end
    join
    report_test(2, "read latency", errs);

    // fill past 16 with reads stopped
    errs = error_count;
    set_rd_en(1'b0);
    repeat (20) @(posedge rd_clk);
    apb_xfer(1'b1, `ADC_REG_STATUS, 32'h3, rdata);
    apb_xfer(1'b1, `ADC_REG_DROPS, 32'h0, rdata);
    read_check(`ADC_REG_STATUS, 32'h4, "STATUS");
    of_before  = of_pulses;
    vld_before = vld_count;
    exp_drops  = 0;
    n = 5 + ({$random(seed)} % 3);
    for (i = 0; i < n; i++) begin
      send_beat(pick_gap(4, 3));
    end
    // drop events cross one per rd_clk cycle
    repeat (60) @(posedge rd_clk);
    check_word(of_pulses - of_before, exp_drops, "fifo_of pulses");
    read_check(`ADC_REG_STATUS, 32'h1, "STATUS");
    read_check(`ADC_REG_DROPS, exp_drops, "DROPS");
    apb_xfer(1'b1, `ADC_REG_STATUS, 32'h1, rdata);
    read_check(`ADC_REG_STATUS, 32'h0, "STATUS");
    r = $random(seed);
    apb_xfer(1'b1, `ADC_REG_DROPS, r, rdata);
    read_check(`ADC_REG_DROPS, 32'h0, "DROPS");
    set_rd_en(1'b1);
    wait_drain();
    check_word(vld_count - vld_before, FIFO_DEPTH, "dout_vld count");
    report_test(3, "overflow", errs);

    // single read strobe on an empty fifo
    errs = error_count;
    set_rd_en(1'b0);
    repeat (10) @(posedge rd_clk);
    apb_xfer(1'b1, `ADC_REG_STATUS, 32'h2, rdata);
    read_check(`ADC_REG_STATUS, 32'h4, "STATUS");
    uf_before  = uf_pulses;
    vld_before = vld_count;
    set_rd_en(1'b1);
    set_rd_en(1'b0);
    repeat (8) @(posedge rd_clk);
    check_word(uf_pulses - uf_before, 1, "fifo_uf pulses");
    check_word(vld_count - vld_before, 0, "dout_vld count");
    read_check(`ADC_REG_STATUS, 32'h6, "STATUS");
    report_test(4, "underflow", errs);

    // beats sent with capture off must not reach the fifo
    errs = error_count;
    apb_xfer(1'b1, `ADC_REG_CTRL, 32'h0, rdata);
    read_check(`ADC_REG_CTRL, 32'h0, "CTRL");
    repeat (5) @(posedge wr_clk);
    set_rd_en(1'b1);
    vld_before  = vld_count;
    model_en    = 1'b0;
    watch_empty = 1'b1;
    for (i = 0; i < OFF_BEATS; i++) begin
      send_beat(pick_gap(4, 4));
    end
    repeat (30) @(posedge rd_clk);
    watch_empty = 1'b0;
    set_rd_en(1'b0);
    check_word(vld_count - vld_before, 0, "dout_vld count");
    report_test(5, "capture enable", errs);

    $display("5 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, check_count, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* adc_retime_top.sv */
`timescale 1ns/10ps

module adc_retime_top (
  input  logic                        wr_clk,
  input  logic                        rd_clk,
  input  logic                        rst_n,
  input  adc_stream_pkg::adc_beat_t   din,
  input  logic                        dvld,
  input  logic                        rd_en,
  input  adc_ctrl_pkg::apb_req_t      apb_req,
  output adc_ctrl_pkg::apb_rsp_t      apb_rsp,
  output adc_stream_pkg::adc_sample_t dout,
  output logic                        dout_vld,
  output logic                        fifo_empty,
  output logic                        fifo_of,
  output logic                        fifo_uf
);

  import adc_stream_pkg::*;
  import adc_ctrl_pkg::*;

  // serialized stream into the fifo
  adc_sample_t  mux_sample;
  logic         mux_vld;
  // enable from the register block, on rd_clk
  logic         capture_en;
  fifo_status_t fifo_status;

  adc_stream_mux u_mux (
    .wr_clk     (wr_clk),
    .rst_n      (rst_n),
    .capture_en (capture_en),
    .din        (din),
    .dvld       (dvld),
    .sample     (mux_sample),
    .sample_vld (mux_vld)
  );

  async_sample_fifo u_fifo (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rst_n   (rst_n),
    .wr_data (mux_sample),
    .wr_en   (mux_vld),
    .rd_en   (rd_en),
    .rd_data (dout),
    .rd_vld  (dout_vld),
    .status  (fifo_status)
  );

  adc_apb_regs u_regs (
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .status     (fifo_status),
    .capture_en (capture_en)
  );

  assign fifo_empty = fifo_status.empty;
  assign fifo_of    = fifo_status.overflow;
  assign fifo_uf    = fifo_status.underflow;

endmodule

/* adc_apb_regs.sv */
`timescale 1ns/10ps

module adc_apb_regs (
  input  logic                       rd_clk,
  input  logic                       rst_n,
  input  adc_ctrl_pkg::apb_req_t     apb_req,
  output adc_ctrl_pkg::apb_rsp_t     apb_rsp,
  input  adc_ctrl_pkg::fifo_status_t status,
  output logic                       capture_en
);

  import adc_ctrl_pkg::*;

  localparam logic [15:0] DROPS_MAX = 16'hffff;

  reg_addr_e   addr;
  logic        wr_acc;
  logic        ctrl_en_q;
  logic        sticky_of_q;
  logic        sticky_uf_q;
  logic [15:0] drops_q;
  logic [31:0] rdata;

  assign addr   = reg_addr_e'(apb_req.paddr);
  // access phase of a write, no wait states
  assign wr_acc = apb_req.psel && apb_req.penable && apb_req.pwrite;

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_en_q   <= 1'b0;
      sticky_of_q <= 1'b0;
      sticky_uf_q <= 1'b0;
      drops_q     <= '0;
    end else begin
      if (wr_acc && addr == REG_CTRL) begin
        ctrl_en_q <= apb_req.pwdata[0];
      end
      // a new event wins over a w1c in the same cycle
      if (status.overflow) begin
        sticky_of_q <= 1'b1;
      end else if (wr_acc && addr == REG_STATUS && apb_req.pwdata[0]) begin
        sticky_of_q <= 1'b0;
      end
      if (status.underflow) begin
        sticky_uf_q <= 1'b1;
      end else if (wr_acc && addr == REG_STATUS && apb_req.pwdata[1]) begin
        sticky_uf_q <= 1'b0;
      end
      // any write clears, saturating count otherwise
      if (wr_acc && addr == REG_DROPS) begin
        drops_q <= {15'd0, status.overflow};
      end else if (status.overflow && drops_q != DROPS_MAX) begin
        drops_q <= drops_q + 16'd1;
      end
    end
  end

  always_comb begin
    case (addr)
      REG_CTRL:   rdata = {31'd0, ctrl_en_q};
      REG_STATUS: rdata = {29'd0, status.empty, sticky_uf_q, sticky_of_q};
      REG_DROPS:  rdata = {16'd0, drops_q};
      default:    rdata = 32'd0;
    endcase
  end

  assign apb_rsp.prdata = rdata;
  assign apb_rsp.pready = 1'b1;
  assign capture_en     = ctrl_en_q;

  // access phase always follows a setup phase
  assert property (@(posedge rd_clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel)
    else $error("adc_apb_regs: penable without psel");

endmodule

/* async_sample_fifo.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module async_sample_fifo (
  input  logic                        wr_clk,
  input  logic                        rd_clk,
  input  logic                        rst_n,
  input  adc_stream_pkg::adc_sample_t wr_data,
  input  logic                        wr_en,
  input  logic                        rd_en,
  output adc_stream_pkg::adc_sample_t rd_data,
  output logic                        rd_vld,
  output adc_ctrl_pkg::fifo_status_t  status
);

  import adc_stream_pkg::*;

  localparam int AW    = `ADC_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i + 1] ^ g[i];
    end
    return b;
  endfunction

  adc_sample_t mem [DEPTH];
  logic [1:0]  wr_rst_pipe;
  logic [1:0]  rd_rst_pipe;
  logic        wr_rst_n;
  logic        rd_rst_n;
  logic [AW:0] wbin_q, wgray_q, wbin_next, wgray_next;
  logic [AW:0] rbin_q, rgray_q, rbin_next, rgray_next;
  logic [AW:0] rgray_w_meta, rgray_w_sync;
  logic [AW:0] wgray_r_meta, wgray_r_sync;
  logic [AW:0] of_cnt_q, of_gray_q, of_gray_meta, of_gray_sync, of_seen_q;
  logic [AW:0] wr_level;
  logic [AW:0] rd_level;
  logic        full_q, empty_q, wr_push, rd_take;
  logic        take_q, mid_vld_q, uf_q, of_pulse_q;
  adc_sample_t head_q, mid_q;

  // async assert with release synced per domain
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_rst_pipe <= 2'b00;
    end else begin
      wr_rst_pipe <= {wr_rst_pipe[0], 1'b1};
    end
  end

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_rst_pipe <= 2'b00;
    end else begin
      rd_rst_pipe <= {rd_rst_pipe[0], 1'b1};
    end
  end

  assign wr_rst_n = wr_rst_pipe[1];
  assign rd_rst_n = rd_rst_pipe[1];

  // write side drops samples when full
  assign wr_push    = wr_en && !full_q;
  assign wbin_next  = wbin_q + {{AW{1'b0}}, wr_push};
  assign wgray_next = bin2gray(wbin_next);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wbin_q       <= '0;
      wgray_q      <= '0;
      rgray_w_meta <= '0;
      rgray_w_sync <= '0;
      full_q       <= 1'b0;
      of_cnt_q     <= '0;
      of_gray_q    <= '0;
    end else begin
      wbin_q       <= wbin_next;
      wgray_q      <= wgray_next;
      rgray_w_meta <= rgray_q;
      rgray_w_sync <= rgray_w_meta;
      // full when the top two gray bits differ and the rest match
      full_q <= (wgray_next == {~rgray_w_sync[AW:AW-1], rgray_w_sync[AW-2:0]});
      // gray coded drop count steps once per dropped sample
      if (wr_en && full_q) begin
        of_cnt_q <= of_cnt_q + 1'b1;
      end
      of_gray_q <= bin2gray(of_cnt_q);
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wbin_q[AW-1:0]] <= wr_data;
    end
  end

  // read side
  assign rd_take    = rd_en && !empty_q;
  assign rbin_next  = rbin_q + {{AW{1'b0}}, rd_take};
  assign rgray_next = bin2gray(rbin_next);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rbin_q       <= '0;
      rgray_q      <= '0;
      wgray_r_meta <= '0;
      wgray_r_sync <= '0;
      empty_q      <= 1'b1;
      take_q       <= 1'b0;
      mid_vld_q    <= 1'b0;
      rd_vld       <= 1'b0;
      uf_q         <= 1'b0;
      of_gray_meta <= '0;
      of_gray_sync <= '0;
      of_seen_q    <= '0;
      of_pulse_q   <= 1'b0;
    end else begin
      rbin_q       <= rbin_next;
      rgray_q      <= rgray_next;
      wgray_r_meta <= wgray_q;
      wgray_r_sync <= wgray_r_meta;
      empty_q      <= (rgray_next == wgray_r_sync);
      // registered read request then two stages to the output
      take_q       <= rd_take;
      mid_vld_q    <= take_q;
      rd_vld       <= mid_vld_q;
      uf_q         <= rd_en && empty_q;
      of_gray_meta <= of_gray_q;
      of_gray_sync <= of_gray_meta;
      // drain one overflow event per cycle
      if (of_seen_q != gray2bin(of_gray_sync)) begin
        of_seen_q  <= of_seen_q + 1'b1;
        of_pulse_q <= 1'b1;
      end else begin
        of_pulse_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (rd_take) begin
      head_q <= mem[rbin_q[AW-1:0]];
    end
    mid_q   <= head_q;
    rd_data <= mid_q;
  end

  assign status.overflow  = of_pulse_q;
  assign status.underflow = uf_q;
  assign status.empty     = empty_q;

  // occupancy seen from either side never exceeds the depth
  assign wr_level = wbin_q - gray2bin(rgray_w_sync);
  assign rd_level = gray2bin(wgray_r_sync) - rbin_q;

  assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_level <= DEPTH)
    else $error("async_sample_fifo: write pointer ran past a full fifo");

  assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_level <= DEPTH)
    else $error("async_sample_fifo: read pointer ran past the write pointer");

endmodule

/* adc_stream_mux.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_stream_mux (
  input  logic                        wr_clk,
  input  logic                        rst_n,
  input  logic                        capture_en,
  input  adc_stream_pkg::adc_beat_t   din,
  input  logic                        dvld,
  output adc_stream_pkg::adc_sample_t sample,
  output logic                        sample_vld
);

  import adc_stream_pkg::*;

  localparam logic [1:0] LAST_IDX = 2'(`ADC_SAMPLES_PER_BEAT - 1);

  logic        en_meta;
  logic        en_sync;
  logic        take_beat;
  mux_state_e  state_q;
  logic [1:0]  idx_q;
  adc_beat_t   shift_q;
  adc_sample_t mux_q;
  logic        mux_vld_q;
  adc_sample_t pipe_q;
  logic        pipe_vld_q;

  // capture enable comes from rd_clk
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      en_meta <= 1'b0;
      en_sync <= 1'b0;
    end else begin
      en_meta <= capture_en;
      en_sync <= en_meta;
    end
  end

  // next beat may load while the last sample goes out
  assign take_beat = dvld && en_sync && (state_q == IDLE || idx_q == LAST_IDX);

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      idx_q   <= 2'd0;
    end else if (take_beat) begin
      state_q <= SHIFT;
      idx_q   <= 2'd0;
    end else if (state_q == SHIFT) begin
      // index wraps back to 0 on the last sample
      idx_q <= idx_q + 2'd1;
      if (idx_q == LAST_IDX) begin
        state_q <= IDLE;
      end
    end
  end

  // shift down, head is always element 0
  always_ff @(posedge wr_clk) begin
    if (take_beat) begin
      shift_q <= din;
    end else if (state_q == SHIFT) begin
      shift_q <= {{`ADC_SAMPLE_W{1'b0}}, shift_q[`ADC_SAMPLES_PER_BEAT-1:1]};
    end
  end

  // serializer output, then pipeline stage toward the fifo
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      mux_vld_q  <= 1'b0;
      pipe_vld_q <= 1'b0;
    end else begin
      mux_vld_q  <= (state_q == SHIFT);
      pipe_vld_q <= mux_vld_q;
    end
  end

  always_ff @(posedge wr_clk) begin
    mux_q.sync <= (idx_q == 2'd0);
    mux_q.data <= shift_q[0];
    pipe_q     <= mux_q;
  end

  assign sample     = pipe_q;
  assign sample_vld = pipe_vld_q;

  // beats arrive no closer than one beat length
  assert property (@(posedge wr_clk) disable iff (!rst_n)
    dvld |-> !(state_q == SHIFT && idx_q != LAST_IDX))
    else $error("adc_stream_mux: dvld inside a running beat");

endmodule

/* adc_ctrl_pkg.sv */
`include "adc_macros.svh"

package adc_ctrl_pkg;

  // apb request, master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // apb response, slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  // register map
  typedef enum logic [3:0] {
    REG_CTRL   = `ADC_REG_CTRL,
    REG_STATUS = `ADC_REG_STATUS,
    REG_DROPS  = `ADC_REG_DROPS
  } reg_addr_e;

  // fifo events, all on rd_clk
  typedef struct packed {
    logic overflow;
    logic underflow;
    logic empty;
  } fifo_status_t;

endpackage

/* adc_stream_pkg.sv */
`include "adc_macros.svh"

package adc_stream_pkg;

  // four samples per beat
  // sample 0 sits in the lowest bits
  typedef logic [`ADC_SAMPLES_PER_BEAT-1:0][`ADC_SAMPLE_W-1:0] adc_beat_t;

  // one sample on the serial stream
  // sync marks sample 0 of each beat
  typedef struct packed {
    logic                     sync;
    logic [`ADC_SAMPLE_W-1:0] data;
  } adc_sample_t;

  // serializer states
  typedef enum logic {
    IDLE  = 1'b0,
    SHIFT = 1'b1
  } mux_state_e;

endpackage

/* adc_macros.svh */
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// one adc sample, two's complement
`define ADC_SAMPLE_W 24

// samples packed into one write-side beat
`define ADC_SAMPLES_PER_BEAT 4

// fifo depth as log2, 16 entries
`define ADC_FIFO_DEPTH_LOG2 4

// apb byte addresses, 4-bit paddr
`define ADC_REG_CTRL   4'h0
`define ADC_REG_STATUS 4'h4
`define ADC_REG_DROPS  4'h8

`endif
